//--- filelist.f
+incdir+hw
hw/crypt_pkg.sv
hw/crypt_req_arbiter.sv
hw/crypt_regs.sv
hw/key_fetch_client.sv
hw/seed_prng.sv
hw/block_xor_engine.sv
hw/crypt_wrapper.sv
tb/tb_clock_gen.sv
tb/crypt_wrapper_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench, pass only if the pass message shows up
verilator --binary --timing -f filelist.f --top-module crypt_wrapper_tb -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep "=== PASS ===" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/crypt_wrapper_tb.sv
module crypt_wrapper_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // About 150 bus accesses of two cycles each plus key fetches is well under this
  localparam int MAX_CYCLES = 4000;
  localparam int RUN_LEN = 4;

  logic clk, reset_n, zeroize_i;
  logic host_dv_i, host_write_i, dma_dv_i, dma_write_i;
  crypt_pkg::reg_addr_t host_addr_i, dma_addr_i;
  crypt_pkg::word_t host_wdata_i, dma_wdata_i, host_rdata_o, dma_rdata_o;
  logic host_hold_o, host_err_o, dma_hold_o, dma_err_o;
  logic kv_rd_req_o, kv_rd_valid_i, kv_rd_last_i, kv_rd_err_i;
  crypt_pkg::kv_entry_t kv_rd_entry_o;
  crypt_pkg::word_t kv_rd_data_i;
  logic idle_o, busy_o, output_valid_o;

  integer seed = 40;
  int cycles = 0;
  int errors = 0;
  int test_mark = 0;
  int tests_run = 0;
  int tests_failed = 0;
  bit vault_fail = 1'b0;
  crypt_pkg::word_t vault_words [4];

  // Model state
  crypt_pkg::word_t m_data_in [4];
  crypt_pkg::word_t m_seed [2];
  bit [1:0] m_seed_seen = 2'b00;
  bit m_swap = 1'b0;
  crypt_pkg::word_t m_lfsr = 32'h1;

  tb_clock_gen u_clock_gen (.clk_o(clk), .reset_n_o(reset_n));

  crypt_wrapper dut (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ==========================================================
  // Key vault responder
  // ==========================================================
  initial begin
    int delay;
    forever begin
      @(posedge clk);
      if (kv_rd_req_o) begin
        delay = 1 + ({$random(seed)} % 3);
        repeat (delay) @(posedge clk);
        if (vault_fail) begin
          kv_rd_err_i <= 1'b1;
          @(posedge clk);
          kv_rd_err_i <= 1'b0;
        end else begin
          for (int i = 0; i < 4; i++) begin
            vault_words[i] = $random(seed);
            kv_rd_valid_i <= 1'b1;
            kv_rd_data_i  <= vault_words[i];
            kv_rd_last_i  <= (i == 3);
            @(posedge clk);
          end
          kv_rd_valid_i <= 1'b0;
          kv_rd_last_i  <= 1'b0;
        end
      end
    end
  end

  // ==========================================================
  // Model helpers
  // ==========================================================
  function automatic crypt_pkg::word_t byte_rev(input crypt_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic crypt_pkg::word_t lfsr_next(input crypt_pkg::word_t s);
    return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
  endfunction

  function automatic bit is_data_addr(input crypt_pkg::reg_addr_t a);
    return (a >= 8'h10 && a <= 8'h1C) || (a >= 8'h20 && a <= 8'h2C);
  endfunction

  task automatic model_write(input crypt_pkg::reg_addr_t a, input crypt_pkg::word_t w);
    crypt_pkg::word_t mix;
    if (a == 8'h00) begin
      m_swap = w[0];
    end else if (a >= 8'h10 && a <= 8'h1C) begin
      m_data_in[a[3:2]] = m_swap ? byte_rev(w) : w;
    end else if (a == 8'h30 || a == 8'h34) begin
      m_seed[a[2]] = w;
      m_seed_seen[a[2]] = 1'b1;
      if (m_seed_seen == 2'b11) begin
        mix = m_seed[0] ^ m_seed[1];
        m_lfsr = (mix == 0) ? 32'h1 : mix;
        m_seed_seen = 2'b00;
      end
    end
  endtask

  task automatic check_value(input string name, input crypt_pkg::word_t expected,
                             input crypt_pkg::word_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_mark) begin
      $display("[TEST] %s: ok", name);
    end else begin
      $display("[TEST] %s: %0d errors", name, errors - test_mark);
      tests_failed++;
    end
    test_mark = errors;
  endtask

  // ==========================================================
  // Bus access that holds dv until the access completes
  // ==========================================================
  task automatic bus_access(input bit use_dma, input bit wr, input crypt_pkg::reg_addr_t a,
                            input crypt_pkg::word_t wdata, output crypt_pkg::word_t rdata,
                            output bit err, output bit held);
    held = 1'b0;
    @(posedge clk);
    if (use_dma) begin
      dma_dv_i <= 1'b1;
      dma_write_i <= wr;
      dma_addr_i <= a;
      dma_wdata_i <= wdata;
    end else begin
      host_dv_i <= 1'b1;
      host_write_i <= wr;
      host_addr_i <= a;
      host_wdata_i <= wdata;
    end
    @(negedge clk);
    while (use_dma ? dma_hold_o : host_hold_o) begin
      held = 1'b1;
      @(negedge clk);
    end
    rdata = use_dma ? dma_rdata_o : host_rdata_o;
    err = use_dma ? dma_err_o : host_err_o;
    @(posedge clk);
    host_dv_i <= 1'b0;
    dma_dv_i <= 1'b0;
  endtask

  task automatic reg_write(input bit use_dma, input crypt_pkg::reg_addr_t a,
                           input crypt_pkg::word_t w);
    crypt_pkg::word_t rd;
    bit err, held;
    bus_access(use_dma, 1'b1, a, w, rd, err, held);
    check_value("write err", 0, err);
    model_write(a, w);
  endtask

  task automatic reg_read(input bit use_dma, input crypt_pkg::reg_addr_t a,
                          output crypt_pkg::word_t rd);
    bit err, held;
    bus_access(use_dma, 1'b0, a, 0, rd, err, held);
    check_value("read err", 0, err);
  endtask

  task automatic wait_key_ready();
    crypt_pkg::word_t st;
    int tries;
    tries = 0;
    reg_read(1'b0, 8'h04, st);
    while (!st[3] && tries < 50) begin
      reg_read(1'b0, 8'h04, st);
      tries++;
    end
    if (!st[3]) begin
      $display("Key client did not return to ready after a vault read");
      errors++;
    end
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    crypt_pkg::word_t w, rd;
    crypt_pkg::reg_addr_t unmapped [4];
    crypt_pkg::reg_addr_t a;
    bit use_dma, err, held;
    int n;
    zeroize_i = 0;
    host_dv_i = 0;
    host_write_i = 0;
    host_addr_i = 0;
    host_wdata_i = 0;
    dma_dv_i = 0;
    dma_write_i = 0;
    dma_addr_i = 0;
    dma_wdata_i = 0;
    kv_rd_valid_i = 0;
    kv_rd_data_i = 0;
    kv_rd_last_i = 0;
    kv_rd_err_i = 0;
    unmapped = '{8'h0C, 8'h38, 8'h40, 8'hFC};
    for (int i = 0; i < 4; i++) begin
      m_data_in[i] = 0;
    end
    m_seed = '{0, 0};
    @(posedge reset_n);
    check_value("idle_o", 1, idle_o);
    check_value("busy_o", 0, busy_o);
    check_value("output_valid_o", 0, output_valid_o);
    check_value("kv_rd_req_o", 0, kv_rd_req_o);

    // Register readback through both ports
    for (int i = 0; i < 24; i++) begin
      use_dma = $random(seed);
      a = ($random(seed) & 1) ? (8'h10 + 8'(({$random(seed)} % 4) * 4))
                              : (8'h30 + 8'(({$random(seed)} % 2) * 4));
      w = $random(seed);
      reg_write(use_dma, a, w);
      reg_read(!use_dma, a, rd);
      check_value("readback rdata", a[5] ? m_seed[a[2]] : m_data_in[a[3:2]], rd);
    end
    for (int i = 0; i < 4; i++) begin
      bus_access(i[0], 1'b0, unmapped[i], 0, rd, err, held);
      check_value("unmapped err", 1, err);
    end
    end_test("register readback");

    // Collision
    @(posedge clk);
    host_dv_i <= 1'b1;
    host_write_i <= 1'b0;
    host_addr_i <= 8'h10;
    dma_dv_i <= 1'b1;
    dma_write_i <= 1'b0;
    dma_addr_i <= 8'h14;
    @(negedge clk);
    check_value("host_err_o", 1, host_err_o);
    check_value("dma_err_o", 1, dma_err_o);
    @(posedge clk);
    host_dv_i <= 1'b0;
    dma_dv_i <= 1'b0;
    end_test("collision");

    // Endian swap
    reg_write(1'b0, 8'h00, 32'h1);
    for (int i = 0; i < 4; i++) begin
      w = $random(seed);
      reg_write(i[0], 8'h10 + 8'(i * 4), w);
      reg_read(!i[0], 8'h10 + 8'(i * 4), rd);
      check_value("swapped readback", w, rd);
    end
    reg_write(1'b1, 8'h00, 32'h0);
    for (int i = 0; i < 4; i++) begin
      reg_read(1'b0, 8'h10 + 8'(i * 4), rd);
      check_value("raw data_in", m_data_in[i], rd);
    end
    end_test("endian swap");

    // Vault error then zeroize of a good key
    vault_fail = 1'b1;
    reg_write(1'b0, 8'h08, 32'h7);
    wait_key_ready();
    reg_read(1'b0, 8'h04, rd);
    check_value("status kv bits after err", 3'b110, rd[4:2]);
    reg_write(1'b0, 8'h00, 32'h2);
    repeat (RUN_LEN + 2) @(negedge clk);
    check_value("output_valid_o", 0, output_valid_o);
    vault_fail = 1'b0;
    reg_write(1'b1, 8'h08, 32'h3);
    wait_key_ready();
    reg_read(1'b0, 8'h04, rd);
    check_value("status kv bits before zeroize", 3'b011, rd[4:2]);
    @(posedge clk);
    zeroize_i <= 1'b1;
    @(posedge clk);
    zeroize_i <= 1'b0;
    reg_read(1'b0, 8'h04, rd);
    check_value("status kv bits after zeroize", 3'b010, rd[4:2]);
    reg_write(1'b0, 8'h00, 32'h2);
    repeat (RUN_LEN + 2) @(negedge clk);
    check_value("output_valid_o", 0, output_valid_o);
    end_test("vault error and zeroize");

    // Key fetch and engine run
    for (int i = 0; i < 4; i++) begin
      reg_write(1'b0, 8'h10 + 8'(i * 4), $random(seed));
    end
    reg_write(1'b0, 8'h08, 32'h9);
    // Request is up in the cycle after the KV_CTRL write
    @(negedge clk);
    check_value("kv_rd_req_o", 1, kv_rd_req_o);
    check_value("kv_rd_entry_o", 4, kv_rd_entry_o);
    wait_key_ready();
    reg_read(1'b1, 8'h04, rd);
    check_value("status after key fetch", 5'b01101, rd[4:0]);
    reg_write(1'b0, 8'h00, 32'h2);
    n = 1;
    @(negedge clk);
    check_value("busy_o", 1, busy_o);
    while (!output_valid_o && n < 20) begin
      @(negedge clk);
      n++;
    end
    check_value("start to output_valid_o cycles", RUN_LEN, n);
    reg_read(1'b0, 8'h04, rd);
    check_value("status after run", 5'b01111, rd[4:0]);
    for (int i = 0; i < 4; i++) begin
      reg_read(i[0], 8'h20 + 8'(i * 4), rd);
      check_value("data_out", m_data_in[i] ^ byte_rev(vault_words[i]), rd);
    end
    reg_write(1'b0, 8'h00, 32'h2);
    bus_access(1'b1, 1'b0, 8'h20, 0, rd, err, held);
    check_value("hold while busy", 1, held);
    check_value("data_out after hold", m_data_in[0] ^ byte_rev(vault_words[0]), rd);
    end_test("key fetch and engine");

    // Entropy
    reg_write(1'b0, 8'h30, $random(seed));
    reg_write(1'b1, 8'h34, $random(seed));
    for (int i = 0; i < 8; i++) begin
      reg_read(i[0], 8'h3C, rd);
      check_value("entropy", m_lfsr, rd);
      m_lfsr = lfsr_next(m_lfsr);
    end
    end_test("entropy");

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic reset_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial clk_o = 1'b0;
  always #5 clk_o = ~clk_o;

  // Reset held for the first 8 rising edges
  initial begin
    reset_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    reset_n_o <= 1'b1;
  end

endmodule

//--- hw/crypt_wrapper.sv
`include "crypt_settings.svh"

module crypt_wrapper (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 zeroize_i,

  // Host port
  input  logic                 host_dv_i,
  input  logic                 host_write_i,
  input  crypt_pkg::reg_addr_t host_addr_i,
  input  crypt_pkg::word_t     host_wdata_i,
  output logic                 host_hold_o,
  output logic                 host_err_o,
  output crypt_pkg::word_t     host_rdata_o,

  // DMA port
  input  logic                 dma_dv_i,
  input  logic                 dma_write_i,
  input  crypt_pkg::reg_addr_t dma_addr_i,
  input  crypt_pkg::word_t     dma_wdata_i,
  output logic                 dma_hold_o,
  output logic                 dma_err_o,
  output crypt_pkg::word_t     dma_rdata_o,

  // Key vault
  output logic                 kv_rd_req_o,
  output crypt_pkg::kv_entry_t kv_rd_entry_o,
  input  logic                 kv_rd_valid_i,
  input  crypt_pkg::word_t     kv_rd_data_i,
  input  logic                 kv_rd_last_i,
  input  logic                 kv_rd_err_i,

  // Status
  output logic                 idle_o,
  output logic                 busy_o,
  output logic                 output_valid_o
);

  logic                                    req_dv, req_write, req_hold, req_err;
  crypt_pkg::reg_addr_t                    req_addr;
  crypt_pkg::word_t                        req_wdata, req_rdata;
  logic                                    endian_swap, start, kv_read_en, entropy_rd;
  crypt_pkg::kv_entry_t                    kv_entry;
  logic [`CRYPT_SEED_WORDS-1:0]            seed_wr;
  crypt_pkg::word_t                        seed0, seed1, entropy;
  crypt_pkg::word_t [`CRYPT_KEY_WORDS-1:0] data_in, data_out;
  crypt_pkg::key_t                         key;
  logic                                    key_valid, kv_ready, kv_error;
  logic                                    eng_idle, out_valid;

  assign idle_o         = eng_idle;
  assign busy_o         = ~eng_idle;
  assign output_valid_o = out_valid;

  crypt_req_arbiter u_arbiter (
    .host_dv_i, .host_write_i, .host_addr_i, .host_wdata_i,
    .host_hold_o, .host_err_o, .host_rdata_o,
    .dma_dv_i, .dma_write_i, .dma_addr_i, .dma_wdata_i,
    .dma_hold_o, .dma_err_o, .dma_rdata_o,
    .endian_swap_i (endian_swap),
    .req_dv_o      (req_dv),
    .req_write_o   (req_write),
    .req_addr_o    (req_addr),
    .req_wdata_o   (req_wdata),
    .req_rdata_i   (req_rdata),
    .req_hold_i    (req_hold),
    .req_err_i     (req_err)
  );

  crypt_regs u_regs (
    .clk, .reset_n,
    .req_dv_i      (req_dv),
    .req_write_i   (req_write),
    .req_addr_i    (req_addr),
    .req_wdata_i   (req_wdata),
    .req_rdata_o   (req_rdata),
    .req_hold_o    (req_hold),
    .req_err_o     (req_err),
    .endian_swap_o (endian_swap),
    .start_o       (start),
    .kv_read_en_o  (kv_read_en),
    .kv_entry_o    (kv_entry),
    .seed_wr_o     (seed_wr),
    .seed0_o       (seed0),
    .seed1_o       (seed1),
    .entropy_rd_o  (entropy_rd),
    .data_in_o     (data_in),
    .eng_idle_i    (eng_idle),
    .out_valid_i   (out_valid),
    .data_out_i    (data_out),
    .key_valid_i   (key_valid),
    .kv_ready_i    (kv_ready),
    .kv_error_i    (kv_error),
    .entropy_i     (entropy)
  );

  key_fetch_client u_key_client (
    .clk, .reset_n, .zeroize_i,
    .read_en_i     (kv_read_en),
    .entry_i       (kv_entry),
    .kv_rd_req_o, .kv_rd_entry_o,
    .kv_rd_valid_i, .kv_rd_data_i, .kv_rd_last_i, .kv_rd_err_i,
    .key_o         (key),
    .key_valid_o   (key_valid),
    .ready_o       (kv_ready),
    .error_o       (kv_error)
  );

  seed_prng u_prng (
    .clk, .reset_n,
    .seed_wr_i (seed_wr),
    .seed0_i   (seed0),
    .seed1_i   (seed1),
    .step_i    (entropy_rd),
    .value_o   (entropy)
  );

  block_xor_engine u_engine (
    .clk, .reset_n,
    .start_i     (start),
    .key_i       (key),
    .key_valid_i (key_valid),
    .data_in_i   (data_in),
    .data_out_o  (data_out),
    .idle_o      (eng_idle),
    .out_valid_o (out_valid)
  );

endmodule

//--- hw/block_xor_engine.sv
`include "crypt_settings.svh"

module block_xor_engine (
  input  logic                                    clk,
  input  logic                                    reset_n,
  input  logic                                    start_i,
  input  crypt_pkg::key_t                         key_i,
  input  logic                                    key_valid_i,
  input  crypt_pkg::word_t [`CRYPT_KEY_WORDS-1:0] data_in_i,
  output crypt_pkg::word_t [`CRYPT_KEY_WORDS-1:0] data_out_o,
  output logic                                    idle_o,
  output logic                                    out_valid_o
);

  crypt_pkg::eng_state_e                   state_q;
  logic [$clog2(`CRYPT_ENG_CYCLES)-1:0]    cnt_q;
  crypt_pkg::word_t [`CRYPT_KEY_WORDS-1:0] result_q;
  logic                                    accept;

  // No start while running or without a key
  assign accept = start_i & key_valid_i & (state_q != crypt_pkg::ENG_RUN);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= crypt_pkg::ENG_IDLE;
      cnt_q    <= '0;
      result_q <= '0;
    end else if (accept) begin
      state_q <= crypt_pkg::ENG_RUN;
      cnt_q   <= '0;
    end else if (state_q == crypt_pkg::ENG_RUN) begin
      // Start cycle counts as the first of the run
      if (cnt_q == $bits(cnt_q)'(`CRYPT_ENG_CYCLES - 2)) begin
        state_q <= crypt_pkg::ENG_DONE;
        for (int i = 0; i < `CRYPT_KEY_WORDS; i++) begin
          result_q[i] <= data_in_i[i] ^ key_i[i*32 +: 32];
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign data_out_o  = result_q;
  assign idle_o      = state_q != crypt_pkg::ENG_RUN;
  assign out_valid_o = state_q == crypt_pkg::ENG_DONE;

endmodule

//--- hw/seed_prng.sv
`include "crypt_settings.svh"

module seed_prng (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic [`CRYPT_SEED_WORDS-1:0] seed_wr_i,
  input  crypt_pkg::word_t             seed0_i,
  input  crypt_pkg::word_t             seed1_i,
  input  logic                         step_i,
  output crypt_pkg::word_t             value_o
);

  logic [`CRYPT_SEED_WORDS-1:0] seed_vld_q;
  logic                         seed_en;
  crypt_pkg::word_t             seed_mix;
  crypt_pkg::word_t             lfsr_q;

  // Reseed once every seed word has been written, then start over
  assign seed_en  = &seed_vld_q;
  assign seed_mix = seed0_i ^ seed1_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      seed_vld_q <= '0;
    end else if (seed_en) begin
      seed_vld_q <= '0;
    end else begin
      seed_vld_q <= seed_vld_q | seed_wr_i;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      lfsr_q <= `CRYPT_LFSR_RESET;
    end else if (seed_en) begin
      // All-zero state would lock up
      lfsr_q <= (seed_mix == '0) ? `CRYPT_LFSR_RESET : seed_mix;
    end else if (step_i) begin
      lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? `CRYPT_LFSR_POLY : 32'h0);
    end
  end

  assign value_o = lfsr_q;

endmodule

//--- hw/key_fetch_client.sv
`include "crypt_settings.svh"

module key_fetch_client (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 zeroize_i,

  // Register side
  input  logic                 read_en_i,
  input  crypt_pkg::kv_entry_t entry_i,

  // Key vault
  output logic                 kv_rd_req_o,
  output crypt_pkg::kv_entry_t kv_rd_entry_o,
  input  logic                 kv_rd_valid_i,
  input  crypt_pkg::word_t     kv_rd_data_i,
  input  logic                 kv_rd_last_i,
  input  logic                 kv_rd_err_i,

  // Engine side
  output crypt_pkg::key_t      key_o,
  output logic                 key_valid_o,
  output logic                 ready_o,
  output logic                 error_o
);

  crypt_pkg::kv_state_e                  state_q;
  crypt_pkg::kv_entry_t                  entry_q;
  logic [$clog2(`CRYPT_KEY_WORDS)-1:0]   cnt_q;
  crypt_pkg::key_t                       key_q;
  logic                                  error_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= crypt_pkg::KV_IDLE;
      entry_q <= '0;
      cnt_q   <= '0;
      key_q   <= '0;
      error_q <= 1'b0;
    end else if (zeroize_i) begin
      state_q <= crypt_pkg::KV_IDLE;
      key_q   <= '0;
    end else if (read_en_i) begin
      // New request drops the old key
      state_q <= crypt_pkg::KV_REQ;
      entry_q <= entry_i;
      cnt_q   <= '0;
      key_q   <= '0;
      error_q <= 1'b0;
    end else begin
      case (state_q)
        crypt_pkg::KV_REQ: begin
          state_q <= crypt_pkg::KV_COLLECT;
        end
        crypt_pkg::KV_COLLECT: begin
          if (kv_rd_err_i) begin
            state_q <= crypt_pkg::KV_IDLE;
            key_q   <= '0;
            error_q <= 1'b1;
          end else if (kv_rd_valid_i) begin
            // Vault words arrive big endian
            key_q[cnt_q*32 +: 32] <= crypt_pkg::bswap(kv_rd_data_i);
            cnt_q <= cnt_q + 1'b1;
            if (kv_rd_last_i) begin
              state_q <= crypt_pkg::KV_DONE;
            end
          end
        end
        default: begin
          state_q <= state_q;
        end
      endcase
    end
  end

  assign kv_rd_req_o   = state_q == crypt_pkg::KV_REQ;
  assign kv_rd_entry_o = entry_q;
  assign key_o         = key_q;
  // DONE is the resting state while the key is published
  assign key_valid_o   = state_q == crypt_pkg::KV_DONE;
  assign ready_o       = (state_q == crypt_pkg::KV_IDLE) || (state_q == crypt_pkg::KV_DONE);
  assign error_o       = error_q;

endmodule

//--- hw/crypt_regs.sv
`include "crypt_settings.svh"

module crypt_regs (
  input  logic                                      clk,
  input  logic                                      reset_n,

  // Merged request
  input  logic                                      req_dv_i,
  input  logic                                      req_write_i,
  input  crypt_pkg::reg_addr_t                      req_addr_i,
  input  crypt_pkg::word_t                          req_wdata_i,
  output crypt_pkg::word_t                          req_rdata_o,
  output logic                                      req_hold_o,
  output logic                                      req_err_o,

  // Control towards the datapath
  output logic                                      endian_swap_o,
  output logic                                      start_o,
  output logic                                      kv_read_en_o,
  output crypt_pkg::kv_entry_t                      kv_entry_o,
  output logic [`CRYPT_SEED_WORDS-1:0]              seed_wr_o,
  output crypt_pkg::word_t                          seed0_o,
  output crypt_pkg::word_t                          seed1_o,
  output logic                                      entropy_rd_o,
  output crypt_pkg::word_t [`CRYPT_KEY_WORDS-1:0]   data_in_o,

  // Status from the datapath
  input  logic                                      eng_idle_i,
  input  logic                                      out_valid_i,
  input  crypt_pkg::word_t [`CRYPT_KEY_WORDS-1:0]   data_out_i,
  input  logic                                      key_valid_i,
  input  logic                                      kv_ready_i,
  input  logic                                      kv_error_i,
  input  crypt_pkg::word_t                          entropy_i
);

  logic                                    is_ctrl, is_status, is_kv_ctrl, is_entropy;
  logic                                    is_data_in, is_data_out, is_seed;
  logic                                    mapped, access, wr, rd;
  logic [1:0]                              word_idx;
  logic                                    swap_q;
  crypt_pkg::kv_entry_t                    kv_entry_q;
  crypt_pkg::word_t [`CRYPT_KEY_WORDS-1:0] data_in_q;
  crypt_pkg::word_t [`CRYPT_SEED_WORDS-1:0] seed_q;

  // ==========================================================
  // Address decode
  // ==========================================================
  assign is_ctrl     = req_addr_i == `CRYPT_ADDR_CTRL;
  assign is_status   = req_addr_i == `CRYPT_ADDR_STATUS;
  assign is_kv_ctrl  = req_addr_i == `CRYPT_ADDR_KV_CTRL;
  assign is_entropy  = req_addr_i == `CRYPT_ADDR_ENTROPY;
  // Array regions, word index masked off
  assign is_data_in  = (req_addr_i & 8'hF3) == `CRYPT_ADDR_DATA_IN;
  assign is_data_out = (req_addr_i & 8'hF3) == `CRYPT_ADDR_DATA_OUT;
  assign is_seed     = (req_addr_i & 8'hFB) == `CRYPT_ADDR_SEED;
  assign word_idx    = req_addr_i[3:2];

  assign mapped = is_ctrl | is_status | is_kv_ctrl | is_entropy |
                  is_data_in | is_data_out | is_seed;

  // Data block is frozen while the engine runs
  assign req_hold_o = req_dv_i & (is_data_in | is_data_out) & ~eng_idle_i;
  assign req_err_o  = req_dv_i & ~mapped;

  assign access = req_dv_i & ~req_hold_o & mapped;
  assign wr     = access & req_write_i;
  assign rd     = access & ~req_write_i;

  // Single cycle pulses on the completing access
  assign start_o       = wr & is_ctrl & req_wdata_i[1];
  assign kv_read_en_o  = wr & is_kv_ctrl & req_wdata_i[0];
  assign kv_entry_o    = req_wdata_i[5:1];
  assign seed_wr_o     = {wr & is_seed & req_addr_i[2], wr & is_seed & ~req_addr_i[2]};
  assign entropy_rd_o  = rd & is_entropy;

  assign endian_swap_o = swap_q;
  assign seed0_o       = seed_q[0];
  assign seed1_o       = seed_q[1];
  assign data_in_o     = data_in_q;

  // ==========================================================
  // Storage
  // ==========================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      swap_q     <= 1'b0;
      kv_entry_q <= '0;
      data_in_q  <= '0;
      seed_q     <= '0;
    end else if (wr) begin
      if (is_ctrl) begin
        swap_q <= req_wdata_i[0];
      end
      if (is_kv_ctrl) begin
        kv_entry_q <= req_wdata_i[5:1];
      end
      if (is_data_in) begin
        data_in_q[word_idx] <= req_wdata_i;
      end
      if (is_seed) begin
        seed_q[req_addr_i[2]] <= req_wdata_i;
      end
    end
  end

  // Read mux, start bit always reads back zero
  always_comb begin
    req_rdata_o = '0;
    if (is_ctrl) begin
      req_rdata_o = {31'b0, swap_q};
    end else if (is_status) begin
      req_rdata_o = {27'b0, kv_error_i, kv_ready_i, key_valid_i, out_valid_i, eng_idle_i};
    end else if (is_kv_ctrl) begin
      req_rdata_o = {26'b0, kv_entry_q, 1'b0};
    end else if (is_data_in) begin
      req_rdata_o = data_in_q[word_idx];
    end else if (is_data_out) begin
      req_rdata_o = data_out_i[word_idx];
    end else if (is_seed) begin
      req_rdata_o = seed_q[req_addr_i[2]];
    end else if (is_entropy) begin
      req_rdata_o = entropy_i;
    end
  end

endmodule

//--- hw/crypt_req_arbiter.sv
`include "crypt_settings.svh"

module crypt_req_arbiter (
  // Host requester
  input  logic                 host_dv_i,
  input  logic                 host_write_i,
  input  crypt_pkg::reg_addr_t host_addr_i,
  input  crypt_pkg::word_t     host_wdata_i,
  output logic                 host_hold_o,
  output logic                 host_err_o,
  output crypt_pkg::word_t     host_rdata_o,

  // DMA requester
  input  logic                 dma_dv_i,
  input  logic                 dma_write_i,
  input  crypt_pkg::reg_addr_t dma_addr_i,
  input  crypt_pkg::word_t     dma_wdata_i,
  output logic                 dma_hold_o,
  output logic                 dma_err_o,
  output crypt_pkg::word_t     dma_rdata_o,

  // Merged request towards the register file
  input  logic                 endian_swap_i,
  output logic                 req_dv_o,
  output logic                 req_write_o,
  output crypt_pkg::reg_addr_t req_addr_o,
  output crypt_pkg::word_t     req_wdata_o,
  input  crypt_pkg::word_t     req_rdata_i,
  input  logic                 req_hold_i,
  input  logic                 req_err_i
);

  logic             collision;
  logic             host_sel;
  logic             swap_en;
  crypt_pkg::word_t wdata_raw;
  crypt_pkg::word_t rdata_post;

  // Firmware keeps the two requesters apart, overlap is only flagged
  assign collision = host_dv_i & dma_dv_i;
  assign host_sel  = host_dv_i & ~dma_dv_i;

  // DMA wins the merged request
  assign req_dv_o    = host_dv_i | dma_dv_i;
  assign req_write_o = dma_dv_i ? dma_write_i : host_write_i;
  assign req_addr_o  = dma_dv_i ? dma_addr_i : host_addr_i;
  assign wdata_raw   = dma_dv_i ? dma_wdata_i : host_wdata_i;

  // Only the DATA_IN and DATA_OUT words get swapped, mask drops the word index
  assign swap_en = endian_swap_i & req_dv_o &
                   (((req_addr_o & 8'hF3) == `CRYPT_ADDR_DATA_IN) ||
                    ((req_addr_o & 8'hF3) == `CRYPT_ADDR_DATA_OUT));

  assign req_wdata_o = swap_en ? crypt_pkg::bswap(wdata_raw) : wdata_raw;
  assign rdata_post  = swap_en ? crypt_pkg::bswap(req_rdata_i) : req_rdata_i;

  // Responses go back to the requester that owns the merged request
  assign host_hold_o  = host_sel & req_hold_i;
  assign dma_hold_o   = dma_dv_i & req_hold_i;
  assign host_err_o   = (host_sel & req_err_i) | collision;
  assign dma_err_o    = (dma_dv_i & req_err_i) | collision;
  assign host_rdata_o = (host_sel & ~req_hold_i) ? rdata_post : '0;
  assign dma_rdata_o  = (dma_dv_i & ~req_hold_i) ? rdata_post : '0;

endmodule

//--- hw/crypt_pkg.sv
`include "crypt_settings.svh"

package crypt_pkg;

  typedef logic [31:0] word_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [4:0]  kv_entry_t;

  // Word 0 sits in the low 32 bits
  typedef logic [`CRYPT_KEY_WORDS*32-1:0] key_t;

  typedef enum logic [1:0] {
    KV_IDLE,
    KV_REQ,
    KV_COLLECT,
    KV_DONE
  } kv_state_e;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_RUN,
    ENG_DONE
  } eng_state_e;

  // Byte reversal, shared by the bus swap and the key swizzle
  function automatic word_t bswap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

//--- hw/crypt_settings.svh
`ifndef CRYPT_SETTINGS_SVH
`define CRYPT_SETTINGS_SVH

// ==========================================================
// Register map, byte offsets inside the block
// ==========================================================
`define CRYPT_ADDR_CTRL      8'h00
`define CRYPT_ADDR_STATUS    8'h04
`define CRYPT_ADDR_KV_CTRL   8'h08
// First word of each array, words follow at 4-byte steps
`define CRYPT_ADDR_DATA_IN   8'h10
`define CRYPT_ADDR_DATA_OUT  8'h20
`define CRYPT_ADDR_SEED      8'h30
`define CRYPT_ADDR_ENTROPY   8'h3C

// ==========================================================
// Sizes and constants
// ==========================================================
`define CRYPT_KEY_WORDS      4
`define CRYPT_SEED_WORDS     2

// Galois taps, shift right form
`define CRYPT_LFSR_POLY      32'hB4BCD35C
`define CRYPT_LFSR_RESET     32'h1

// Start to output valid, in clock cycles
`define CRYPT_ENG_CYCLES     4

`endif
